// File: sweep_analyzer.f
hdl/sweep_pkg.sv
hdl/zero_cross_detector.sv
hdl/sweep_sequencer.sv
hdl/gain_phase_meter.sv
hdl/ratio_divider.sv
hdl/sweep_analyzer.sv
testbench/tb_sweep_analyzer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sweep analyzer testbench with verilator
# all paths are relative to the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sweep_analyzer -o tb_sweep_analyzer \
  -f sweep_analyzer.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sweep_analyzer > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
  echo "simulation reported failures, see $log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
if ! grep -q "NO ERRORS" "$log"; then
  echo "simulation ended without a result line, see $log"
  exit 1
fi
echo "simulation passed"
exit 0

// File: hdl/freq_table.hex
08000000
04000000
02000000
01000000
08000000
04000000
02000000
01000000
08000000
04000000
02000000
01000000
08000000
04000000
02000000
01000000

// File: testbench/sweep_input.txt
# test line: last_point glitch_enable
# point line: amp_a amp_b delay_samples expected_magnitude expected_phase
3 0
4000 2000 3 1000 3
1500 1500 5 0 5
1000 3000 9 -667 9
7000 900 20 6777 20
1 0
2500 5000 0 -500 0
6000 2000 7 2000 7
5 1
3000 1000 2 2000 2
800 800 11 0 11
1200 5000 17 -760 17
5000 3000 31 666 31
8000 250 4 31000 4
350 7000 13 -950 13

// File: testbench/tb_sweep_analyzer.sv
module tb_sweep_analyzer;

  timeunit 1ns;
  timeprecision 1ps;

  import sweep_pkg::*;

  localparam string INPUT_FILE = "testbench/sweep_input.txt";
  localparam int CLK_PERIOD_NS = 20;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES = 100;
  localparam int EXC_AMP = 4096;
  localparam int HIST_DEPTH = 64;
  localparam int GLITCH_SEQ_LEN = 256;

  logic       clk125;
  logic       areset_n;
  logic       start;
  point_t     last_point;
  sample_t    dds_sample = '0;
  logic       dds_valid = 1'b0;
  sample_t    adc_a = '0;
  sample_t    adc_b = '0;
  phase_inc_t phase_inc;
  point_t     point_index;
  logic       sweep_done;
  logic       result_valid;
  acc_t       magnitude;
  acc_t       phase_delay;
  point_t     result_point;

  // one entry per test, then flat per-point columns
  int test_last[$];
  int test_glitch[$];
  int pt_amp_a[$];
  int pt_amp_b[$];
  int pt_delay[$];
  int pt_mag[$];
  int pt_phase[$];

  // first point of the running test, glitch switch
  int test_base = 0;
  bit glitch_en = 1'b0;

  // dds model state
  logic [31:0] phase;
  logic [31:0] inc_q;
  logic [31:0] phase_hist [0:HIST_DEPTH-1];
  int          glitch_seq [0:GLITCH_SEQ_LEN-1];
  int          glitch_ptr [0:2];

  sweep_analyzer i_sweep_analyzer (
    .clk125      (clk125),
    .areset_n    (areset_n),
    .start       (start),
    .last_point  (last_point),
    .dds_sample  (dds_sample),
    .dds_valid   (dds_valid),
    .adc_a       (adc_a),
    .adc_b       (adc_b),
    .phase_inc   (phase_inc),
    .point_index (point_index),
    .sweep_done  (sweep_done),
    .result_valid(result_valid),
    .magnitude   (magnitude),
    .phase_delay (phase_delay),
    .result_point(result_point)
  );

  always #(CLK_PERIOD_NS / 2) clk125 = ~clk125;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string test_name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s expected %0d actual %0d", test_name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // triangle, zero at phase 0, exact peaks at 1/4 and 3/4 of a cycle
  function automatic int triangle(input logic [31:0] ph, input int amp);
    int x;
    x = int'(ph[31:16]);
    if (x < 16384)
      return amp * x / 16384;
    else if (x < 49152)
      return amp * (32768 - x) / 16384;
    else
      return amp * (x - 65536) / 16384;
  endfunction

  // rom repeats periods 32, 64, 128, 256
  function automatic int point_period(input int k);
    return 32 << (k % 4);
  endfunction

  // next data line, comments and blank lines skipped
  function automatic bit next_line(input int fd, output string line);
    int n;
    n = $fgets(line, fd);
    while (n != 0 && (line.len() < 2 || line.getc(0) == "#"))
      n = $fgets(line, fd);
    return n != 0;
  endfunction

  task automatic load_tests();
    int    fd;
    string line;
    int    lp;
    int    gl;
    int    a;
    int    b;
    int    d;
    int    m;
    int    p;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0)
      abort_run($sformatf("cannot open stimulus file %s", INPUT_FILE));
    while (next_line(fd, line))
    begin
      if ($sscanf(line, "%d %d", lp, gl) != 2 || lp < 0 || lp > 15)
        abort_run($sformatf("malformed test line in stimulus file: %s", line));
      test_last.push_back(lp);
      test_glitch.push_back(gl);
      for (int k = 0; k <= lp; k++)
      begin
        if (!next_line(fd, line))
          abort_run("stimulus file ends in the middle of a test");
        if ($sscanf(line, "%d %d %d %d %d", a, b, d, m, p) != 5)
          abort_run($sformatf("malformed point line in stimulus file: %s", line));
        // file values against the ratio rule, 2a*1000 / 2b minus offset
        check_value($sformatf("input test%0d point %0d magnitude rule", test_last.size(), k),
                    (2 * a * SHUNT_SCALE) / (2 * b) - SHUNT_SCALE, m);
        check_value($sformatf("input test%0d point %0d phase rule", test_last.size(), k),
                    d, p);
        pt_amp_a.push_back(a);
        pt_amp_b.push_back(b);
        pt_delay.push_back(d);
        pt_mag.push_back(m);
        pt_phase.push_back(p);
      end
    end
    $fclose(fd);
    if (test_last.size() == 0)
      abort_run("stimulus file holds no tests");
  endtask

  // settle, arm and window periods plus margin, doubled
  function automatic longint sweep_time_ns();
    longint total;
    total = 0;
    foreach (test_last[t])
      for (int k = 0; k <= test_last[t]; k++)
        total += longint'(point_period(k)) * (SETTLE_CROSSINGS + MEAS_CYCLES + 3)
                 * CLK_PERIOD_NS;
    return 2 * total;
  endfunction

  task automatic watchdog(input longint limit_ns);
    #(limit_ns);
    abort_run($sformatf("timeout: sweeps did not complete within %0d ns", limit_ns));
  endtask

  // dds model, phase cleared on every new tuning word
  always @(negedge clk125)
  begin : dds_model
    logic [31:0] ch_phase [0:2];
    int          ch_val [0:2];
    int          idx;
    if (!areset_n)
    begin
      phase = '0;
      inc_q = '0;
      for (int i = 0; i < HIST_DEPTH; i++)
        phase_hist[i] = '0;
      dds_valid  <= 1'b0;
      dds_sample <= '0;
      adc_a      <= '0;
      adc_b      <= '0;
    end
    else
    begin
      if (phase_inc != inc_q)
      begin
        inc_q = phase_inc;
        phase = '0;
      end
      else
        phase = phase + inc_q;
      for (int i = HIST_DEPTH - 1; i > 0; i--)
        phase_hist[i] = phase_hist[i-1];
      phase_hist[0] = phase;
      // channel settings follow the point under sweep
      idx = test_base + int'(point_index);
      if (idx >= pt_amp_a.size())
        idx = pt_amp_a.size() - 1;
      ch_phase[0] = phase;
      ch_phase[1] = phase;
      ch_phase[2] = phase_hist[pt_delay[idx]];
      ch_val[0] = triangle(ch_phase[0], EXC_AMP);
      ch_val[1] = triangle(ch_phase[1], pt_amp_a[idx]);
      ch_val[2] = triangle(ch_phase[2], pt_amp_b[idx]);
      // one sample early in the rising quarter, well above the trough
      for (int c = 0; c < 3; c++)
        if (glitch_en && ch_phase[c] == inc_q * 32'(glitch_seq[glitch_ptr[c]]))
        begin
          ch_val[c] = -1;
          glitch_ptr[c] = (glitch_ptr[c] + 1) % GLITCH_SEQ_LEN;
        end
      dds_valid  <= 1'b1;
      dds_sample <= sample_t'(ch_val[0]);
      adc_a      <= sample_t'(ch_val[1]);
      adc_b      <= sample_t'(ch_val[2]);
    end
  end

  task automatic run_sweep(input int t, input int base);
    string tag;
    int    lp;
    lp  = test_last[t];
    tag = $sformatf("test%0d", t + 1);
    test_base <= base;
    glitch_en <= (test_glitch[t] != 0);
    @(negedge clk125);
    last_point <= point_t'(lp);
    start      <= 1'b1;
    for (int k = 0; k <= lp; k++)
    begin
      @(negedge clk125);
      while (result_valid !== 1'b1)
      begin
        // done only after the last result
        check_value($sformatf("%s sweep_done before point %0d", tag, k), 0, sweep_done);
        @(negedge clk125);
      end
      check_value($sformatf("%s point %0d result_point", tag, k), k, result_point);
      check_value($sformatf("%s point %0d magnitude", tag, k), pt_mag[base + k], magnitude);
      check_value($sformatf("%s point %0d phase_delay", tag, k), pt_phase[base + k],
                  phase_delay);
    end
    @(negedge clk125);
    while (sweep_done !== 1'b1)
    begin
      check_value($sformatf("%s extra result before done", tag), 0, result_valid);
      @(negedge clk125);
    end
    // start still high, done holds and no more results
    repeat (HOLD_CYCLES)
    begin
      @(negedge clk125);
      check_value($sformatf("%s sweep_done hold", tag), 1, sweep_done);
      check_value($sformatf("%s extra result after last point", tag), 0, result_valid);
    end
    start <= 1'b0;
    @(negedge clk125);
    check_value($sformatf("%s sweep_done after start low", tag), 0, sweep_done);
    check_value($sformatf("%s point_index after sweep", tag), 0, point_index);
  endtask

  initial
  begin : main
    int base;
    clk125     = 1'b0;
    areset_n   = 1'b0;
    start      = 1'b0;
    last_point = '0;
    void'($urandom(32'hb573));
    // glitch sample index in the rising half, 1 to 5
    for (int i = 0; i < GLITCH_SEQ_LEN; i++)
      glitch_seq[i] = 1 + int'($urandom % 5);
    for (int c = 0; c < 3; c++)
      glitch_ptr[c] = c;
    load_tests();
    fork
      watchdog(sweep_time_ns());
    join_none
    repeat (RESET_CYCLES) @(negedge clk125);
    areset_n <= 1'b1;
    repeat (4) @(negedge clk125);
    check_value("idle after reset sweep_done", 0, sweep_done);
    check_value("idle after reset result_valid", 0, result_valid);
    check_value("idle after reset point_index", 0, point_index);
    // first tuning word is 2^32 / 32
    check_value("idle after reset phase_inc", 64'h0800_0000, phase_inc);
    base = 0;
    for (int t = 0; t < test_last.size(); t++)
    begin
      run_sweep(t, base);
      base += test_last[t] + 1;
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: hdl/sweep_analyzer.sv
module sweep_analyzer (
  input  logic                  clk125,
  input  logic                  areset_n,
  input  logic                  start,
  input  sweep_pkg::point_t     last_point,
  input  sweep_pkg::sample_t    dds_sample,
  input  logic                  dds_valid,
  input  sweep_pkg::sample_t    adc_a,
  input  sweep_pkg::sample_t    adc_b,
  output sweep_pkg::phase_inc_t phase_inc,
  output sweep_pkg::point_t     point_index,
  output logic                  sweep_done,
  output logic                  result_valid,
  output sweep_pkg::acc_t       magnitude,
  output sweep_pkg::acc_t       phase_delay,
  output sweep_pkg::point_t     result_point
);

  import sweep_pkg::*;

  logic    exc_crossing;
  logic    crossing_a;
  logic    crossing_b;
  sample_t sample_a;
  sample_t sample_b;
  logic    meas_start;
  logic    meas_done;
  acc_t    amp_a;
  acc_t    amp_b;
  acc_t    delay_q;
  acc_t    numerator;
  acc_t    quotient;
  logic    div_done;
  point_t  pending_point;
  logic    seq_done;
  logic    last_result_seen;

  // excitation detector only paces settling
  zero_cross_detector i_exc_detector (.clk125(clk125), .areset_n(areset_n),
    .sample(dds_sample), .sample_q(), .crossing(exc_crossing));

  zero_cross_detector i_a_detector (.clk125(clk125), .areset_n(areset_n),
    .sample(adc_a), .sample_q(sample_a), .crossing(crossing_a));

  zero_cross_detector i_b_detector (.clk125(clk125), .areset_n(areset_n),
    .sample(adc_b), .sample_q(sample_b), .crossing(crossing_b));

  sweep_sequencer i_sweep_sequencer (.clk125(clk125), .areset_n(areset_n),
    .start(start), .last_point(last_point), .dds_valid(dds_valid),
    .exc_crossing(exc_crossing), .meas_done(meas_done), .meas_start(meas_start),
    .point_index(point_index), .phase_inc(phase_inc), .sweep_done(seq_done));

  gain_phase_meter i_gain_phase_meter (.clk125(clk125), .areset_n(areset_n),
    .meas_start(meas_start), .sample_a(sample_a), .sample_b(sample_b),
    .crossing_a(crossing_a), .crossing_b(crossing_b), .meas_done(meas_done),
    .amp_a(amp_a), .amp_b(amp_b), .delay_q(delay_q));

  // scale a before dividing so the ratio keeps three decimals
  assign numerator = amp_a * SHUNT_SCALE;

  ratio_divider i_ratio_divider (.clk125(clk125), .areset_n(areset_n),
    .div_start(meas_done), .numerator(numerator), .denominator(amp_b),
    .quotient(quotient), .div_done(div_done));

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      result_valid <= 1'b0;
    else
      result_valid <= div_done;
  end

  // last division still runs when the sequencer reaches done
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      last_result_seen <= 1'b0;
    else
      last_result_seen <= seq_done && (last_result_seen || result_valid);
  end

  // done follows the last result, drops with the sequencer
  assign sweep_done = seq_done && last_result_seen;

  // index sampled before the sequencer advances it
  // division always ends before the next window does
  always_ff @(posedge clk125)
  begin
    if (meas_done)
      pending_point <= point_index;
    if (div_done)
    begin
      magnitude    <= quotient - SHUNT_SCALE;
      phase_delay  <= delay_q;
      result_point <= pending_point;
    end
  end

endmodule

// File: hdl/ratio_divider.sv
module ratio_divider (
  input  logic            clk125,
  input  logic            areset_n,
  input  logic            div_start,
  input  sweep_pkg::acc_t numerator,
  input  sweep_pkg::acc_t denominator,
  output sweep_pkg::acc_t quotient,
  output logic            div_done
);

  import sweep_pkg::*;

  logic [$clog2(ACC_W + 1)-1:0] bit_cnt;
  logic [ACC_W-1:0] quo_q;
  logic [ACC_W-1:0] rem_q;
  logic [ACC_W-1:0] den_q;
  logic [ACC_W:0]   partial;
  logic [ACC_W:0]   diff;
  logic             fits;

  // next numerator bit shifted into the remainder
  assign partial  = {rem_q, quo_q[ACC_W-1]};
  assign diff     = partial - {1'b0, den_q};
  assign fits     = partial >= {1'b0, den_q};
  assign quotient = acc_t'(quo_q);

  // one quotient bit per cycle, done after the last one
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      bit_cnt  <= '0;
      div_done <= 1'b0;
    end
    else
    begin
      div_done <= 1'b0;
      if (div_start)
        bit_cnt <= $clog2(ACC_W + 1)'(ACC_W);
      else if (bit_cnt != 0)
      begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 1)
          div_done <= 1'b1;
      end
    end
  end

  // restoring step
  // zero divisor always fits, so the quotient ends all ones
  always_ff @(posedge clk125)
  begin
    if (div_start)
    begin
      quo_q <= numerator;
      rem_q <= '0;
      den_q <= denominator;
    end
    else if (bit_cnt != 0)
    begin
      quo_q <= {quo_q[ACC_W-2:0], fits};
      rem_q <= fits ? diff[ACC_W-1:0] : partial[ACC_W-1:0];
    end
  end

  a_start_when_idle: assert property (@(posedge clk125) disable iff (!areset_n)
    div_start |-> bit_cnt == 0);

endmodule

// File: hdl/gain_phase_meter.sv
module gain_phase_meter (
  input  logic               clk125,
  input  logic               areset_n,
  input  logic               meas_start,
  input  sweep_pkg::sample_t sample_a,
  input  sweep_pkg::sample_t sample_b,
  input  logic               crossing_a,
  input  logic               crossing_b,
  output logic               meas_done,
  output sweep_pkg::acc_t    amp_a,
  output sweep_pkg::acc_t    amp_b,
  output sweep_pkg::acc_t    delay_q
);

  import sweep_pkg::*;

  meter_state_t state;
  logic [$clog2(MEAS_CYCLES + 1)-1:0] cycle_cnt;
  acc_t    delay_cnt;
  logic    b_seen;
  sample_t max_a;
  sample_t min_a;
  sample_t max_b;
  sample_t min_b;

  // window control, delay count and result outputs
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state     <= MTR_IDLE;
      cycle_cnt <= '0;
      delay_cnt <= '0;
      b_seen    <= 1'b0;
      meas_done <= 1'b0;
      amp_a     <= '0;
      amp_b     <= '0;
      delay_q   <= '0;
    end
    else
    begin
      meas_done <= 1'b0;
      if (meas_start)
      begin
        // new point, drop the old results
        state     <= MTR_ARM;
        cycle_cnt <= '0;
        delay_cnt <= '0;
        b_seen    <= 1'b0;
        amp_a     <= '0;
        amp_b     <= '0;
        delay_q   <= '0;
      end
      else
      begin
        case (state)
          MTR_ARM:
            // window opens on an a crossing
            if (crossing_a)
            begin
              state  <= MTR_TRACK;
              b_seen <= crossing_b;
            end
          MTR_TRACK:
          begin
            // cycles from the opening a crossing up to the first b crossing
            if (!b_seen)
            begin
              delay_cnt <= delay_cnt + 1;
              b_seen    <= crossing_b;
            end
            if (crossing_a)
            begin
              if (cycle_cnt == MEAS_CYCLES - 1)
                state <= MTR_FINISH;
              else
                cycle_cnt <= cycle_cnt + 1'b1;
            end
          end
          MTR_FINISH:
          begin
            // full peak to peak, sign extended from sample width
            amp_a     <= acc_t'(max_a) - acc_t'(min_a);
            amp_b     <= acc_t'(max_b) - acc_t'(min_b);
            delay_q   <= delay_cnt;
            meas_done <= 1'b1;
            state     <= MTR_IDLE;
          end
          default:
            state <= MTR_IDLE;
        endcase
      end
    end
  end

  // peak tracking, seeded with the first sample of the window
  always_ff @(posedge clk125)
  begin
    if (state == MTR_ARM && crossing_a)
    begin
      max_a <= sample_a;
      min_a <= sample_a;
      max_b <= sample_b;
      min_b <= sample_b;
    end
    else if (state == MTR_TRACK)
    begin
      if (sample_a > max_a)
        max_a <= sample_a;
      if (sample_a < min_a)
        min_a <= sample_a;
      if (sample_b > max_b)
        max_b <= sample_b;
      if (sample_b < min_b)
        min_b <= sample_b;
    end
  end

endmodule

// File: hdl/sweep_sequencer.sv
module sweep_sequencer (
  input  logic                  clk125,
  input  logic                  areset_n,
  input  logic                  start,
  input  sweep_pkg::point_t     last_point,
  input  logic                  dds_valid,
  input  logic                  exc_crossing,
  input  logic                  meas_done,
  output logic                  meas_start,
  output sweep_pkg::point_t     point_index,
  output sweep_pkg::phase_inc_t phase_inc,
  output logic                  sweep_done
);

  import sweep_pkg::*;

  seq_state_t state;
  point_t     last_q;
  logic [$clog2(SETTLE_CROSSINGS + 1)-1:0] settle_cnt;

  // frequency table, one tuning word per point
  phase_inc_t freq_rom [0:2**POINT_W-1];

  initial
  begin
    $readmemh(FREQ_TABLE_FILE, freq_rom);
  end

  // index only moves on a point advance or sweep end
  assign phase_inc = freq_rom[point_index];

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state       <= SEQ_IDLE;
      last_q      <= '0;
      point_index <= '0;
      settle_cnt  <= '0;
      meas_start  <= 1'b0;
      sweep_done  <= 1'b0;
    end
    else
    begin
      meas_start <= 1'b0;
      case (state)
        SEQ_IDLE:
          if (start)
          begin
            // sweep length fixed for the whole run
            last_q <= last_point;
            state  <= SEQ_WAIT_DDS;
          end
        SEQ_WAIT_DDS:
          if (dds_valid)
          begin
            settle_cnt <= '0;
            state      <= SEQ_SETTLE;
          end
        SEQ_SETTLE:
          // let the excitation run a few periods at the new frequency
          if (exc_crossing)
          begin
            if (settle_cnt == SETTLE_CROSSINGS - 1)
            begin
              settle_cnt <= '0;
              meas_start <= 1'b1;
              state      <= SEQ_MEASURE;
            end
            else
              settle_cnt <= settle_cnt + 1'b1;
          end
        SEQ_MEASURE:
          if (meas_done)
          begin
            if (point_index == last_q)
            begin
              sweep_done <= 1'b1;
              state      <= SEQ_DONE;
            end
            else
            begin
              point_index <= point_index + 1'b1;
              state       <= SEQ_SETTLE;
            end
          end
        SEQ_DONE:
          // hold done until the host drops start
          if (!start)
          begin
            sweep_done  <= 1'b0;
            point_index <= '0;
            state       <= SEQ_IDLE;
          end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  // meter must only finish a window this fsm opened
  a_done_in_measure: assert property (@(posedge clk125) disable iff (!areset_n)
    meas_done |-> state == SEQ_MEASURE);

endmodule

// File: hdl/zero_cross_detector.sv
module zero_cross_detector (
  input  logic               clk125,
  input  logic               areset_n,
  input  sweep_pkg::sample_t sample,
  output sweep_pkg::sample_t sample_q,
  output logic               crossing
);

  import sweep_pkg::*;

  // waiting for positive half, counting the run, armed for the fall
  typedef enum logic [1:0] {DET_NEG, DET_COUNT, DET_ARMED} det_state_t;

  det_state_t            state;
  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic                  negative;

  // sign of the registered sample drives the fsm
  assign negative = sample_q[SAMPLE_W-1];

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      sample_q <= '0;
    else
      sample_q <= sample;
  end

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state    <= DET_NEG;
      hold_cnt <= '0;
      crossing <= 1'b0;
    end
    else
    begin
      crossing <= 1'b0;
      case (state)
        DET_NEG:
          if (!negative)
          begin
            state    <= DET_COUNT;
            hold_cnt <= HOLD_CNT_W'(1);
          end
        DET_COUNT:
          // a glitch inside the run starts over
          if (negative)
          begin
            state    <= DET_NEG;
            hold_cnt <= '0;
          end
          else if (hold_cnt < DETECT_HOLD)
            hold_cnt <= hold_cnt + 1'b1;
          else
          begin
            state    <= DET_ARMED;
            hold_cnt <= '0;
          end
        DET_ARMED:
          // first negative sample after a long enough run
          if (negative)
          begin
            state    <= DET_NEG;
            crossing <= 1'b1;
          end
        default:
        begin
          state    <= DET_NEG;
          hold_cnt <= '0;
        end
      endcase
    end
  end

  // one pulse per falling edge of the waveform
  a_single_pulse: assert property (@(posedge clk125) disable iff (!areset_n)
    crossing |=> !crossing);

endmodule

// File: hdl/sweep_pkg.sv
package sweep_pkg;

  // adc and dds sample format
  localparam int SAMPLE_W = 14;
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // amplitude, delay and ratio results
  localparam int ACC_W = 32;
  typedef logic signed [ACC_W-1:0] acc_t;

  // tuning word for the external dds
  localparam int PHASE_INC_W = 32;
  typedef logic [PHASE_INC_W-1:0] phase_inc_t;

  // sweep point index, sixteen points max
  localparam int POINT_W = 4;
  typedef logic [POINT_W-1:0] point_t;

  // rom image, path relative to the run directory
  localparam string FREQ_TABLE_FILE = "hdl/freq_table.hex";

  // detector hysteresis
  // nonnegative run needed before a negative sample counts
  localparam int DETECT_HOLD = 10;
  localparam int HOLD_CNT_W = 8;

  // sweep timing
  localparam int SETTLE_CROSSINGS = 2;
  localparam int MEAS_CYCLES = 4;

  // ratio scale, also removed again as offset
  localparam int SHUNT_SCALE = 1000;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_WAIT_DDS,
    SEQ_SETTLE,
    SEQ_MEASURE,
    SEQ_DONE
  } seq_state_t;

  typedef enum logic [1:0] {MTR_IDLE, MTR_ARM, MTR_TRACK, MTR_FINISH} meter_state_t;

endpackage
